/* rtl/msg_pkg.sv */
// Shared sizes and message formats of the core-to-core message exchange.
// Every RTL block imports this package, and the testbench uses it too.
// A destination is one bit wider than a core index, so the upper half
// of the destination space has no core behind it.

`default_nettype none

package msg_pkg;

  // number of cores on the exchange
  localparam int num_cores = 4;

  // core index width
  localparam int core_w = $clog2(num_cores);

  // destination carries one extra bit
  // values num_cores and up are unmapped
  localparam int dest_w = core_w + 1;

  // slot address and payload widths, as the cores use them
  localparam int slot_w = 5;
  localparam int data_w = 32;

  // entries held per mailbox
  localparam int mbox_depth = 4;

  // sender request, held stable while req is high
  typedef struct packed {
    logic              req;
    logic [dest_w-1:0] dest;
    logic [slot_w-1:0] slot;
    logic [data_w-1:0] data;
  } tx_req_t;

  // response back to the sender, both bits last one cycle
  typedef struct packed {
    logic gnt;
    logic err;
  } tx_rsp_t;

  // message as a core receives it
  typedef struct packed {
    logic [core_w-1:0] src;
    logic [slot_w-1:0] slot;
    logic [data_w-1:0] data;
  } rx_msg_t;

  // routed beat broadcast from the arbiter to all mailboxes
  typedef struct packed {
    logic              valid;
    logic [dest_w-1:0] dest;
    rx_msg_t           msg;
  } route_beat_t;

endpackage

`default_nettype wire

/* rtl/msg_fifo.sv */
// Message FIFO behind each core's delivery port.
// First-word-fall-through: the oldest entry is on head_o whenever
// empty_o is low, and pop_i removes it on the clock edge.
// The owner must not push when full or pop when empty.

`timescale 1ns/1ns
`default_nettype none

module msg_fifo #(
  parameter int depth = msg_pkg::mbox_depth
) (
  input  logic             clk_sys,
  input  logic             rst_i,
  input  logic             push_i,
  input  msg_pkg::rx_msg_t push_msg_i,
  input  logic             pop_i,
  output msg_pkg::rx_msg_t head_o,
  output logic             empty_o,
  output logic             full_o
);
  import msg_pkg::*;

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  // message storage and ring pointers
  rx_msg_t          mem_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
    if (int'(ptr) == depth - 1) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // pointers and occupancy
  always_ff @(posedge clk_sys) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // simultaneous push and pop leave the count alone
      count_q <= count_q + cnt_w'(push_i) - cnt_w'(pop_i);
    end
  end

  always_ff @(posedge clk_sys) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_msg_i;
    end
  end

  // oldest entry falls through to the output
  assign head_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_w'(depth));

  // overflow would drop a message that was already granted
  a_no_push_full : assert property (@(posedge clk_sys) disable iff (rst_i)
    full_o |-> !push_i || pop_i);

  a_no_pop_empty : assert property (@(posedge clk_sys) disable iff (rst_i)
    empty_o |-> !pop_i);

endmodule

`default_nettype wire

/* rtl/msg_arbiter.sv */
// Round-robin arbiter in front of the per-core mailboxes.
// Grants at most one sender per cycle, answering gnt and err
// combinationally, and registers the winner's message as a routed beat
// that every mailbox sees on the next cycle. A request to an unmapped
// destination is granted with err set and produces no beat.
// Senders hold their request until gnt, mailboxes report full on dest_full_i.

`timescale 1ns/1ns
`default_nettype none

module msg_arbiter (
  input  logic                          clk_sys,
  input  logic                          rst_i,
  input  msg_pkg::tx_req_t              tx_req_i [msg_pkg::num_cores],
  output msg_pkg::tx_rsp_t              tx_rsp_o [msg_pkg::num_cores],
  input  logic [msg_pkg::num_cores-1:0] dest_full_i,
  output msg_pkg::route_beat_t          beat_o
);
  import msg_pkg::*;

  // round-robin start point, first sender to look at
  logic [core_w-1:0]    ptr_q;

  // per-sender qualification
  logic [num_cores-1:0] unmapped;
  logic [num_cores-1:0] eligible;
  logic [num_cores-1:0] gnt_vec;

  // selection result of this cycle
  logic                 win_found;
  logic [core_w-1:0]    win_idx;

  // registered beat
  logic                 beat_valid_q;
  logic [dest_w-1:0]    beat_dest_q;
  rx_msg_t              beat_msg_q;

  // a sender may go when its target can take the message
  // unmapped targets never block, they are answered with err
  always_comb begin
    for (int i = 0; i < num_cores; i++) begin
      unmapped[i] = (tx_req_i[i].dest >= dest_w'(num_cores));
      eligible[i] = tx_req_i[i].req &&
                    (unmapped[i] || !dest_full_i[tx_req_i[i].dest[core_w-1:0]]);
    end
  end

  // first eligible sender at or after the pointer wins
  always_comb begin
    win_found = 1'b0;
    win_idx   = '0;
    for (int k = 0; k < num_cores; k++) begin
      if (!win_found && eligible[(int'(ptr_q) + k) % num_cores]) begin
        win_found = 1'b1;
        win_idx   = core_w'((int'(ptr_q) + k) % num_cores);
      end
    end
  end

  // responses in the same cycle as the selection
  always_comb begin
    for (int i = 0; i < num_cores; i++) begin
      gnt_vec[i]      = win_found && (win_idx == core_w'(i));
      tx_rsp_o[i].gnt = gnt_vec[i];
      tx_rsp_o[i].err = gnt_vec[i] && unmapped[i];
    end
  end

  // pointer moves past the winner
  // beat valid only for a mapped destination
  always_ff @(posedge clk_sys) begin
    if (rst_i) begin
      ptr_q        <= '0;
      beat_valid_q <= 1'b0;
    end else begin
      if (win_found) begin
        ptr_q <= core_w'((int'(win_idx) + 1) % num_cores);
      end
      beat_valid_q <= win_found && !unmapped[win_idx];
    end
  end

  // payload of the beat, source index stamped from the winner
  always_ff @(posedge clk_sys) begin
    if (win_found) begin
      beat_dest_q     <= tx_req_i[win_idx].dest;
      beat_msg_q.src  <= win_idx;
      beat_msg_q.slot <= tx_req_i[win_idx].slot;
      beat_msg_q.data <= tx_req_i[win_idx].data;
    end
  end

  assign beat_o = '{valid: beat_valid_q, dest: beat_dest_q, msg: beat_msg_q};

  // one message per cycle into the mailboxes
  a_one_grant : assert property (@(posedge clk_sys) disable iff (rst_i)
    $onehot0(gnt_vec));

endmodule

`default_nettype wire

/* rtl/core_mailbox.sv */
// Mailbox of one core.
// Takes every routed beat whose destination equals core_id, buffers it,
// and offers it to the core on a valid/ack port. The message stays on
// rx_msg_o until the core acks it on a clock edge with valid high.
// full_o tells the arbiter to stop granting to this core. It counts the
// beat already on its way, so a granted message always finds room.

`timescale 1ns/1ns
`default_nettype none

module core_mailbox #(
  parameter int core_id = 0
) (
  input  logic                 clk_sys,
  input  logic                 rst_i,
  input  msg_pkg::route_beat_t beat_i,
  output logic                 full_o,
  output logic                 rx_valid_o,
  output msg_pkg::rx_msg_t     rx_msg_o,
  input  logic                 rx_ack_i
);
  import msg_pkg::*;

  localparam int level_w = $clog2(mbox_depth + 1);

  logic               push;
  logic               pop;
  logic               fifo_empty;

  // messages held here, seen from the arbiter side
  logic [level_w-1:0] level_q;

  // beat addressed to this core
  assign push = beat_i.valid && (beat_i.dest == dest_w'(core_id));

  // message leaves on valid and ack together
  assign pop        = rx_valid_o && rx_ack_i;
  assign rx_valid_o = !fifo_empty;

  // stored entries plus the beat arriving now
  // a grant in this cycle would land after that beat
  assign full_o = (int'(level_q) + int'(push)) >= mbox_depth;

  always_ff @(posedge clk_sys) begin
    if (rst_i) begin
      level_q <= '0;
    end else begin
      level_q <= level_q + level_w'(push) - level_w'(pop);
    end
  end

  msg_fifo #(
    .depth      (mbox_depth)
  ) u_fifo (
    .clk_sys    (clk_sys),
    .rst_i      (rst_i),
    .push_i     (push),
    .push_msg_i (beat_i.msg),
    .pop_i      (pop),
    .head_o     (rx_msg_o),
    .empty_o    (fifo_empty),
    .full_o     ()
  );

  // core may sample at leisure
  a_hold_msg : assert property (@(posedge clk_sys) disable iff (rst_i)
    (rx_valid_o && !rx_ack_i) |=> rx_valid_o && $stable(rx_msg_o));

endmodule

`default_nettype wire

/* rtl/msg_exchange_top.sv */
// Top level of the core-to-core message exchange.
// Sender ports request with tx_req_i and get gnt/err on tx_rsp_o.
// One arbiter feeds a mailbox per core, and each mailbox drives that
// core's rx_valid_o / rx_msg_o and takes its rx_ack_i.
// With an empty mailbox a message is offered two cycles after its grant.

`timescale 1ns/1ns
`default_nettype none

module msg_exchange_top (
  input  logic                          clk_sys,
  input  logic                          rst_i,
  // sender side
  input  msg_pkg::tx_req_t              tx_req_i [msg_pkg::num_cores],
  output msg_pkg::tx_rsp_t              tx_rsp_o [msg_pkg::num_cores],
  // receiver side, one port per core
  output logic [msg_pkg::num_cores-1:0] rx_valid_o,
  output msg_pkg::rx_msg_t              rx_msg_o [msg_pkg::num_cores],
  input  logic [msg_pkg::num_cores-1:0] rx_ack_i
);
  import msg_pkg::*;

  // beat broadcast to every mailbox
  route_beat_t          beat;

  // back-pressure, one bit per destination core
  logic [num_cores-1:0] mbox_full;

  msg_arbiter u_arbiter (
    .clk_sys     (clk_sys),
    .rst_i       (rst_i),
    .tx_req_i    (tx_req_i),
    .tx_rsp_o    (tx_rsp_o),
    .dest_full_i (mbox_full),
    .beat_o      (beat)
  );

  // one mailbox per core
  // each picks its own beats by core_id
  for (genvar c = 0; c < num_cores; c++) begin : g_mbox
    core_mailbox #(
      .core_id    (c)
    ) u_mbox (
      .clk_sys    (clk_sys),
      .rst_i      (rst_i),
      .beat_i     (beat),
      .full_o     (mbox_full[c]),
      .rx_valid_o (rx_valid_o[c]),
      .rx_msg_o   (rx_msg_o[c]),
      .rx_ack_i   (rx_ack_i[c])
    );
  end

endmodule

`default_nettype wire

/* include/tb_msg_checks.svh */
// Compare tasks for the message exchange testbench.
// Include inside the testbench module after msg_pkg is compiled.
// Each mismatch prints one Error line and bumps error_count.

`ifndef TB_MSG_CHECKS_SVH
`define TB_MSG_CHECKS_SVH

// mismatches seen so far
int error_count = 0;

// sender response, gnt and err together
task automatic compare_rsp(input string name,
                           input msg_pkg::tx_rsp_t got,
                           input msg_pkg::tx_rsp_t exp);
  if (got !== exp) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

// delivered message, all fields shown
task automatic compare_msg(input string name,
                           input msg_pkg::rx_msg_t got,
                           input msg_pkg::rx_msg_t exp);
  if (got !== exp) begin
    $display("Error: %s is src 0x%h slot 0x%h data 0x%h, expected src 0x%h slot 0x%h data 0x%h",
             name, got.src, got.slot, got.data, exp.src, exp.slot, exp.data);
    error_count++;
  end
endtask

// single control bit such as rx_valid_o
task automatic compare_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
    error_count++;
  end
endtask

`endif

/* verif/tb_msg_exchange.sv */
// Testbench of the message exchange top level.
// Reads the trace, drives sends and acks on the falling clock edge and
// checks every cycle against a model of the round-robin arbiter and the
// mailbox pipeline. Delivered messages are matched per source against
// the expected deliveries of the trace or of the LFSR traffic.

`timescale 1ns/1ns
`default_nettype none

module tb_msg_exchange;
  import msg_pkg::*;

  localparam int half_period  = 50;
  localparam int test_timeout = 2000;
  localparam int min_cycles   = 4;

  typedef struct {
    int          test;
    string       cmd;
    int          src;
    int          dest;
    logic [31:0] slot;
    logic [31:0] data;
  } trace_line_t;

  logic                 clk_sys;
  logic                 rst_i;
  tx_req_t              tx_req_i [num_cores];
  tx_rsp_t              tx_rsp_o [num_cores];
  logic [num_cores-1:0] rx_valid_o;
  rx_msg_t              rx_msg_o [num_cores];
  logic [num_cores-1:0] rx_ack_i;

  `include "tb_msg_checks.svh"

  trace_line_t          trace_q [$];
  // pending sends per source, expected deliveries per destination
  tx_req_t              send_q [num_cores][$];
  rx_msg_t              exp_q [num_cores][$];
  int                   ack_mode [num_cores];
  int                   ack_delay [num_cores];
  // model state: rr pointer, buffered count, beat in flight
  int                   rr_ptr;
  int                   fifo_cnt [num_cores];
  logic [num_cores-1:0] beat_pend;
  logic [7:0]           lfsr_q;
  logic                 aborted;
  int                   tests_run;
  int                   tests_bad;

  msg_exchange_top uut (
    .clk_sys    (clk_sys),
    .rst_i      (rst_i),
    .tx_req_i   (tx_req_i),
    .tx_rsp_o   (tx_rsp_o),
    .rx_valid_o (rx_valid_o),
    .rx_msg_o   (rx_msg_o),
    .rx_ack_i   (rx_ack_i)
  );

  initial begin
    clk_sys = 1'b0;
    forever #half_period clk_sys = ~clk_sys;
  end

  // x^8 + x^6 + x^5 + x^4 + 1, one step per bit
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    trace_line_t t;
    fd = $fopen("verif/msg_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file verif/msg_trace.txt");
      aborted = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank lines and comment lines
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %s %d %d %h %h", t.test, t.cmd, t.src, t.dest, t.slot, t.data);
          if (n == 6) begin
            trace_q.push_back(t);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic load_line(input trace_line_t t);
    tx_req_t req;
    rx_msg_t msg;
    int      d;
    if (t.cmd == "ack") begin
      ack_mode[t.src]  = t.dest;
      ack_delay[t.src] = t.data;
    end else if (t.cmd == "expect") begin
      msg.src  = core_w'(t.src);
      msg.slot = slot_w'(t.slot);
      msg.data = t.data;
      exp_q[t.dest].push_back(msg);
    end else if (t.cmd == "send" && t.slot == 32'hff) begin
      // LFSR run, destination steps through every core
      for (int k = 0; k < int'(t.data); k++) begin
        d        = (t.dest + k) % num_cores;
        req.req  = 1'b1;
        req.dest = dest_w'(d);
        req.slot = slot_w'(rand_bits(slot_w));
        req.data = rand_bits(data_w);
        send_q[t.src].push_back(req);
        msg.src  = core_w'(t.src);
        msg.slot = req.slot;
        msg.data = req.data;
        exp_q[d].push_back(msg);
      end
    end else if (t.cmd == "send") begin
      req.req  = 1'b1;
      req.dest = dest_w'(t.dest);
      req.slot = slot_w'(t.slot);
      req.data = t.data;
      send_q[t.src].push_back(req);
    end else begin
      $display("unknown trace command %s in test %0d", t.cmd, t.test);
      error_count++;
    end
  endtask

  // match the head of a mailbox against the oldest entry from its source
  task automatic check_delivery(input int d, input logic pop);
    int hit;
    hit = -1;
    for (int i = exp_q[d].size() - 1; i >= 0; i--) begin
      if (exp_q[d][i].src == rx_msg_o[d].src) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      $display("core %0d was offered a message from core %0d that it should not get",
               d, rx_msg_o[d].src);
      error_count++;
    end else begin
      compare_msg($sformatf("rx_msg_o[%0d]", d), rx_msg_o[d], exp_q[d][hit]);
      if (pop) begin
        exp_q[d].delete(hit);
      end
    end
  endtask

  task automatic run_test(input int test_no);
    int                   cycles;
    int                   errs_before;
    int                   winner;
    int                   c;
    logic                 busy;
    logic [num_cores-1:0] ack;
    logic [num_cores-1:0] exp_valid;
    logic [num_cores-1:0] exp_full;
    tx_rsp_t              exp_rsp;
    errs_before = error_count;
    cycles      = 0;
    busy        = 1'b1;
    while (busy && !aborted) begin
      @(negedge clk_sys);
      for (int s = 0; s < num_cores; s++) begin
        tx_req_i[s] = (send_q[s].size() > 0) ? send_q[s][0] : '0;
        case (ack_mode[s])
          0:       ack[s] = 1'b0;
          1:       ack[s] = (cycles >= ack_delay[s]);
          default: ack[s] = 1'(rand_bits(1));
        endcase
      end
      rx_ack_i = ack;
      // sample a quarter period before the rising edge
      #(half_period / 2);
      // full counts the beat in flight
      for (int d = 0; d < num_cores; d++) begin
        exp_valid[d] = (fifo_cnt[d] > 0);
        exp_full[d]  = (fifo_cnt[d] + int'(beat_pend[d])) >= mbox_depth;
      end
      // first eligible sender at or after the pointer
      winner = -1;
      for (int k = 0; k < num_cores; k++) begin
        c = (rr_ptr + k) % num_cores;
        if (winner < 0 && tx_req_i[c].req &&
            (int'(tx_req_i[c].dest) >= num_cores || !exp_full[int'(tx_req_i[c].dest)])) begin
          winner = c;
        end
      end
      for (int s = 0; s < num_cores; s++) begin
        exp_rsp.gnt = (winner == s);
        exp_rsp.err = (winner == s) && (int'(tx_req_i[s].dest) >= num_cores);
        compare_rsp($sformatf("tx_rsp_o[%0d]", s), tx_rsp_o[s], exp_rsp);
        compare_bit($sformatf("rx_valid_o[%0d]", s), rx_valid_o[s], exp_valid[s]);
        if (exp_valid[s]) begin
          check_delivery(s, ack[s]);
        end
      end
      // advance the model to the next edge
      for (int d = 0; d < num_cores; d++) begin
        fifo_cnt[d] = fifo_cnt[d] + int'(beat_pend[d]) - int'(exp_valid[d] && ack[d]);
      end
      beat_pend = '0;
      if (winner >= 0) begin
        if (int'(tx_req_i[winner].dest) < num_cores) begin
          beat_pend[tx_req_i[winner].dest[core_w-1:0]] = 1'b1;
        end
        rr_ptr = (winner + 1) % num_cores;
        void'(send_q[winner].pop_front());
      end
      cycles++;
      busy = (cycles < min_cycles) || (beat_pend != '0);
      for (int q = 0; q < num_cores; q++) begin
        if (send_q[q].size() > 0 || fifo_cnt[q] > 0) begin
          busy = 1'b1;
        end
      end
      if (busy && cycles >= test_timeout) begin
        $display("test %0d timed out after %0d cycles with messages still pending",
                 test_no, cycles);
        aborted = 1'b1;
      end
    end
    for (int d = 0; d < num_cores; d++) begin
      foreach (exp_q[d][i]) begin
        $display("core %0d never received slot 0x%h from core %0d",
                 d, exp_q[d][i].slot, exp_q[d][i].src);
        error_count++;
      end
      exp_q[d].delete();
    end
    tests_run++;
    if (error_count != errs_before || aborted) begin
      tests_bad++;
    end
    $display("test %0d done, %0d cycles, %0d errors", test_no, cycles, error_count - errs_before);
  endtask

  initial begin
    int idx;
    int test_no;
    rst_i     = 1'b1;
    rx_ack_i  = '0;
    rr_ptr    = 0;
    beat_pend = '0;
    lfsr_q    = 8'd84;
    aborted   = 1'b0;
    tests_run = 0;
    tests_bad = 0;
    for (int c = 0; c < num_cores; c++) begin
      tx_req_i[c] = '0;
      fifo_cnt[c] = 0;
    end
    read_trace();
    // ten rising edges in reset, outputs idle throughout
    for (int k = 0; k < 10; k++) begin
      @(negedge clk_sys);
      rst_i = (k < 9);
      #(half_period / 2);
      for (int c = 0; c < num_cores; c++) begin
        compare_rsp($sformatf("tx_rsp_o[%0d]", c), tx_rsp_o[c], '0);
        compare_bit($sformatf("rx_valid_o[%0d]", c), rx_valid_o[c], 1'b0);
      end
    end
    idx = 0;
    while (idx < trace_q.size() && !aborted) begin
      test_no = trace_q[idx].test;
      // acks default to always high for each test
      for (int c = 0; c < num_cores; c++) begin
        ack_mode[c]  = 1;
        ack_delay[c] = 0;
      end
      while (idx < trace_q.size() && trace_q[idx].test == test_no) begin
        load_line(trace_q[idx]);
        idx++;
      end
      run_test(test_no);
    end
    $display("%0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, error_count);
    if (error_count == 0 && !aborted && tests_run > 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
rtl/msg_pkg.sv
rtl/msg_fifo.sv
rtl/msg_arbiter.sv
rtl/core_mailbox.sv
rtl/msg_exchange_top.sv
verif/tb_msg_exchange.sv

/* verif/msg_trace.txt */
# columns: test command src dest slot(hex) data(hex)
# ack: core in src, mode in dest (0 low, 1 high after data cycles, 2 random); slot ff: LFSR run
1 ack 0 1 00 00000000
2 send 0 1 01 10000001
2 send 1 2 02 20000002
2 send 2 3 03 30000003
2 send 3 0 04 40000004
2 expect 0 1 01 10000001
2 expect 1 2 02 20000002
2 expect 2 3 03 30000003
2 expect 3 0 04 40000004
3 send 2 1 05 50000005
3 expect 2 1 05 50000005
4 send 0 2 06 60000006
4 send 1 3 07 70000007
4 send 2 0 08 80000008
4 send 3 1 09 90000009
4 expect 0 2 06 60000006
4 expect 1 3 07 70000007
4 expect 2 0 08 80000008
4 expect 3 1 09 90000009
5 send 1 3 0a cafe0001
5 expect 1 3 0a cafe0001
6 ack 0 1 00 0000000c
6 send 2 0 10 a0000000
6 send 2 0 11 a0000001
6 send 2 0 12 a0000002
6 send 2 0 13 a0000003
6 send 2 0 14 a0000004
6 expect 2 0 10 a0000000
6 expect 2 0 11 a0000001
6 expect 2 0 12 a0000002
6 expect 2 0 13 a0000003
6 expect 2 0 14 a0000004
7 send 3 5 1f deadbeef
8 ack 0 2 00 00000000
8 ack 1 2 00 00000000
8 ack 2 2 00 00000000
8 ack 3 2 00 00000000
8 send 0 0 ff 00000008
8 send 1 1 ff 00000008
8 send 2 2 ff 00000008
8 send 3 3 ff 00000008
